//--- Bender.yml
package:
  name: single_cycle_core

sources:
  - source/rvIsaPkg.sv
  - source/cpuCorePkg.sv
  - source/ctrlIf.sv
  - source/controlDecoder.sv
  - source/immGen.sv
  - source/registerFile.sv
  - source/executeUnit.sv
  - source/programCounter.sv
  - source/singleCycleCore.sv
  - target: test
    files:
      - tb/coreChecker.sv
      - tb/tbSingleCycleCore.sv

//--- compile.f
source/rvIsaPkg.sv
source/cpuCorePkg.sv
source/ctrlIf.sv
source/controlDecoder.sv
source/immGen.sv
source/registerFile.sv
source/executeUnit.sv
source/programCounter.sv
source/singleCycleCore.sv
tb/coreChecker.sv
tb/tbSingleCycleCore.sv

//--- source/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
    input  logic           rstN,
    input  rvIsaPkg::instT inst,
    ctrlIf.decoder         ctrl
);

    rvIsaPkg::opcodeT opcode;
    rvIsaPkg::funct3T funct3;

    logic              regWriteDec;
    logic              memWriteDec;
    logic              aluSrcDec;
    logic              memToRegDec;
    logic              branchDec;
    cpuCorePkg::aluOpT aluOpDec;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // ALU control from funct3, subSel only matters for add/sub
    function automatic cpuCorePkg::aluOpT decodeAluOp(
        input rvIsaPkg::funct3T f3,
        input logic             subSel
    );
        cpuCorePkg::aluOpT op;
        case (f3)
            rvIsaPkg::f3AddSub: op = subSel ? cpuCorePkg::aluSub : cpuCorePkg::aluAdd;
            rvIsaPkg::f3Slt:    op = cpuCorePkg::aluSlt;
            rvIsaPkg::f3Or:     op = cpuCorePkg::aluOr;
            rvIsaPkg::f3And:    op = cpuCorePkg::aluAnd;
            default:            op = cpuCorePkg::aluAdd;
        endcase
        return op;
    endfunction

    always_comb begin
        // Unknown opcodes fall through as no-ops
        regWriteDec = 1'b0;
        memWriteDec = 1'b0;
        aluSrcDec   = 1'b0;
        memToRegDec = 1'b0;
        branchDec   = 1'b0;
        aluOpDec    = cpuCorePkg::aluAdd;

        case (opcode)
            rvIsaPkg::opR: begin
                regWriteDec = 1'b1;
                aluOpDec    = decodeAluOp(funct3, inst[rvIsaPkg::subBit]);
            end
            rvIsaPkg::opImm: begin
                regWriteDec = 1'b1;
                aluSrcDec   = 1'b1;
                aluOpDec    = decodeAluOp(funct3, 1'b0); // No subi
            end
            rvIsaPkg::opLoad: begin
                if (funct3 == rvIsaPkg::f3Word) begin // Only lw
                    regWriteDec = 1'b1;
                    aluSrcDec   = 1'b1;
                    memToRegDec = 1'b1;
                end
            end
            rvIsaPkg::opStore: begin
                if (funct3 == rvIsaPkg::f3Word) begin
                    aluSrcDec   = 1'b1;
                    memWriteDec = 1'b1;
                end
            end
            rvIsaPkg::opBranch: begin
                branchDec = (funct3 == rvIsaPkg::f3Beq);
                aluOpDec  = cpuCorePkg::aluSub;
            end
            default: ;
        endcase
    end

    // No state changes while held in reset
    assign ctrl.regWrite = regWriteDec & rstN;
    assign ctrl.memWrite = memWriteDec & rstN;
    assign ctrl.aluSrc   = aluSrcDec;
    assign ctrl.memToReg = memToRegDec;
    assign ctrl.branch   = branchDec;
    assign ctrl.aluOp    = aluOpDec;

endmodule

`default_nettype wire

//--- source/cpuCorePkg.sv
`default_nettype none

package cpuCorePkg;

    localparam int wordW   = 32;
    localparam int numRegs = 32;

    typedef logic [wordW-1:0] wordT;

    // Byte distance between sequential instructions
    localparam wordT pcStep = 32'd4;

    // Operations the ALU can perform
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

endpackage

`default_nettype wire

//--- source/ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;

    logic              regWrite;  // Write back to rd
    logic              aluSrc;    // Second operand is the immediate
    logic              memToReg;  // Write back load data
    logic              memWrite;  // Store strobe
    logic              branch;    // beq in flight
    cpuCorePkg::aluOpT aluOp;

    modport decoder (
        output regWrite,
        output aluSrc,
        output memToReg,
        output memWrite,
        output branch,
        output aluOp
    );

    modport datapath (
        input regWrite,
        input aluSrc,
        input memToReg,
        input memWrite,
        input branch,
        input aluOp
    );

endinterface

`default_nettype wire

//--- source/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  cpuCorePkg::wordT rd1,
    input  cpuCorePkg::wordT rd2,
    input  cpuCorePkg::wordT imm,
    output cpuCorePkg::wordT aluResult,
    output logic             branchTaken,
    ctrlIf.datapath          ctrl
);

    cpuCorePkg::wordT opA;
    cpuCorePkg::wordT opB;
    logic             lessThan;

    assign opA = rd1;
    assign opB = ctrl.aluSrc ? imm : rd2; // Immediate for I, load and store

    // slt compares as two's complement
    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (ctrl.aluOp)
            cpuCorePkg::aluAdd: aluResult = opA + opB;
            cpuCorePkg::aluSub: aluResult = opA - opB;
            cpuCorePkg::aluAnd: aluResult = opA & opB;
            cpuCorePkg::aluOr:  aluResult = opA | opB;
            cpuCorePkg::aluSlt: aluResult = {{(cpuCorePkg::wordW-1){1'b0}}, lessThan};
            default:            aluResult = '0;
        endcase
    end

    // beq compares the two register values directly
    assign branchTaken = ctrl.branch && (rd1 == rd2);

endmodule

`default_nettype wire

//--- source/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  rvIsaPkg::instT   inst,
    output cpuCorePkg::wordT imm
);

    rvIsaPkg::opcodeT opcode;

    cpuCorePkg::wordT immI;
    cpuCorePkg::wordT immS;
    cpuCorePkg::wordT immB;

    assign opcode = inst[6:0];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    // Branch offset already in bytes
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        case (opcode)
            rvIsaPkg::opStore:  imm = immS;
            rvIsaPkg::opBranch: imm = immB;
            rvIsaPkg::opImm,
            rvIsaPkg::opLoad:   imm = immI;
            default:            imm = '0; // R-type has no immediate
        endcase
    end

endmodule

`default_nettype wire

//--- source/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter #(
    parameter cpuCorePkg::wordT resetPc = '0
) (
    input  logic             CLK,
    input  logic             rstN,
    input  cpuCorePkg::wordT imm,
    input  logic             branchTaken,
    output cpuCorePkg::wordT pc
);

    cpuCorePkg::wordT pcPlus4;
    cpuCorePkg::wordT pcTarget;
    cpuCorePkg::wordT nextPc;

    assign pcPlus4  = pc + cpuCorePkg::pcStep;
    assign pcTarget = pc + imm;              // imm already byte offset
    assign nextPc   = branchTaken ? pcTarget : pcPlus4;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic              CLK,
    input  logic              rstN,
    input  rvIsaPkg::regIdxT  rs1,
    input  rvIsaPkg::regIdxT  rs2,
    input  rvIsaPkg::regIdxT  rd,
    input  cpuCorePkg::wordT  aluResult,
    input  cpuCorePkg::wordT  loadData,
    output cpuCorePkg::wordT  rd1,
    output cpuCorePkg::wordT  rd2,
    ctrlIf.datapath           ctrl
);

    // x0 has no storage
    cpuCorePkg::wordT regs [1:cpuCorePkg::numRegs-1];
    cpuCorePkg::wordT wrData;

    assign wrData = ctrl.memToReg ? loadData : aluResult;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < cpuCorePkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && (rd != '0)) begin
            regs[rd] <= wrData;
        end
    end

    // Combinational reads
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- source/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // Field widths of the base encoding
    localparam int instW   = 32;
    localparam int opcodeW = 7;
    localparam int funct3W = 3;
    localparam int regIdxW = 5;

    typedef logic [instW-1:0]   instT;
    typedef logic [opcodeW-1:0] opcodeT;
    typedef logic [funct3W-1:0] funct3T;
    typedef logic [regIdxW-1:0] regIdxT;

    // Major opcodes handled by the core
    localparam opcodeT opR      = 7'b0110011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;

    // funct3 values for the ALU group
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    localparam funct3T f3Word = 3'b010; // lw / sw width
    localparam funct3T f3Beq  = 3'b000;

    // Bit 30 picks sub over add in R-type
    localparam int subBit = 30;

endpackage

`default_nettype wire

//--- source/singleCycleCore.sv
`timescale 1ns/1ps
`default_nettype none

module singleCycleCore #(
    parameter cpuCorePkg::wordT resetPc = '0
) (
    input  logic             CLK,
    input  logic             rstN,
    output cpuCorePkg::wordT instAddr,
    input  rvIsaPkg::instT   inst,
    output cpuCorePkg::wordT memAddr,
    output cpuCorePkg::wordT memWdata,
    output logic             memWe,
    input  cpuCorePkg::wordT memRdata
);

    rvIsaPkg::regIdxT rs1;
    rvIsaPkg::regIdxT rs2;
    rvIsaPkg::regIdxT rd;

    cpuCorePkg::wordT imm;
    cpuCorePkg::wordT rd1;
    cpuCorePkg::wordT rd2;
    cpuCorePkg::wordT aluResult;
    logic             branchTaken;

    ctrlIf ctrl ();

    // Register fields
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    programCounter #(
        .resetPc(resetPc)
    ) programCounter_i (
        .CLK        (CLK),
        .rstN       (rstN),
        .imm        (imm),
        .branchTaken(branchTaken),
        .pc         (instAddr)
    );

    controlDecoder controlDecoder_i (
        .rstN(rstN),
        .inst(inst),
        .ctrl(ctrl.decoder)
    );

    immGen immGen_i (
        .inst(inst),
        .imm (imm)
    );

    registerFile registerFile_i (
        .CLK      (CLK),
        .rstN     (rstN),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .aluResult(aluResult),
        .loadData (memRdata),
        .rd1      (rd1),
        .rd2      (rd2),
        .ctrl     (ctrl.datapath)
    );

    executeUnit executeUnit_i (
        .rd1        (rd1),
        .rd2        (rd2),
        .imm        (imm),
        .aluResult  (aluResult),
        .branchTaken(branchTaken),
        .ctrl       (ctrl.datapath)
    );

    // Data memory port
    assign memAddr  = aluResult;
    assign memWdata = rd2;
    assign memWe    = ctrl.memWrite;

endmodule

`default_nettype wire

//--- tb/coreChecker.sv
`timescale 1ns/1ps
`default_nettype none

module coreChecker #(
    parameter cpuCorePkg::wordT resetPc = '0
) (
    input logic             CLK,
    input logic             rstN,
    input cpuCorePkg::wordT instAddr,
    input rvIsaPkg::instT   inst,
    input logic             memWe
);

    int assertFails = 0; // Failed assertion count

    // Writes are gated while in reset
    aWeInReset: assert property (@(posedge CLK) !rstN |-> !memWe)
        else begin
            assertFails++;
            $error("memWe high while rstN is low");
        end

    aPcAligned: assert property (@(posedge CLK) instAddr[1:0] == 2'b00)
        else begin
            assertFails++;
            $error("instAddr %h is not word aligned", instAddr);
        end

    // First fetch after reset comes from the reset vector
    aResetPc: assert property (@(posedge CLK) $rose(rstN) |-> instAddr == resetPc)
        else begin
            assertFails++;
            $error("instAddr %h is not the reset PC after reset", instAddr);
        end

    aWeOnStore: assert property (@(posedge CLK) disable iff (!rstN)
        memWe |-> inst[6:0] == rvIsaPkg::opStore)
        else begin
            assertFails++;
            $error("memWe high for opcode %b", inst[6:0]);
        end

endmodule

bind singleCycleCore coreChecker #(
    .resetPc(resetPc)
) coreChecker_i (
    .CLK     (CLK),
    .rstN    (rstN),
    .instAddr(instAddr),
    .inst    (inst),
    .memWe   (memWe)
);

`default_nettype wire

//--- tb/tbSingleCycleCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbSingleCycleCore;

    localparam int progWords = 256;
    localparam int dataWords = 64;
    localparam int haltWord  = 248; // Self-branches from here on
    localparam int maxCycles = 2000;

    typedef enum int {kAdd, kSub, kAnd, kOr, kSlt, kAddi, kAndi, kOri, kLw, kSw, kBeq,
                      kIllegal} kindT;

    logic             CLK;
    logic             rstN;
    cpuCorePkg::wordT instAddr;
    rvIsaPkg::instT   inst;
    cpuCorePkg::wordT memAddr;
    cpuCorePkg::wordT memWdata;
    logic             memWe;
    cpuCorePkg::wordT memRdata;

    rvIsaPkg::instT   imem [progWords];
    cpuCorePkg::wordT dmem [dataWords];

    // Program kept as fields for the model
    kindT             progKind [progWords];
    rvIsaPkg::regIdxT progRd   [progWords];
    rvIsaPkg::regIdxT progRs1  [progWords];
    rvIsaPkg::regIdxT progRs2  [progWords];
    cpuCorePkg::wordT progImm  [progWords];

    cpuCorePkg::wordT mRegs [8];
    cpuCorePkg::wordT mMem  [dataWords];
    cpuCorePkg::wordT mPc;
    logic [31:0]      rngState;

    singleCycleCore #(
        .resetPc(32'h0)
    ) singleCycleCore_i (
        .CLK     (CLK),
        .rstN    (rstN),
        .instAddr(instAddr),
        .inst    (inst),
        .memAddr (memAddr),
        .memWdata(memWdata),
        .memWe   (memWe),
        .memRdata(memRdata)
    );

    // Both memories read combinationally
    assign inst     = imem[instAddr[9:2]];
    assign memRdata = dmem[memAddr[7:2]];

    always @(posedge CLK) begin
        if (memWe) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Bound assertions count their failures in the checker
    always @(singleCycleCore_i.coreChecker_i.assertFails) begin
        if (singleCycleCore_i.coreChecker_i.assertFails != 0) begin
            $display("A bound assertion on the core failed");
            $display("Test failures found");
            $fatal(1, "Assertion failure");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Standard RV32I encodings
    function automatic rvIsaPkg::instT encode(input kindT kind, input rvIsaPkg::regIdxT rd,
        input rvIsaPkg::regIdxT rs1, input rvIsaPkg::regIdxT rs2, input cpuCorePkg::wordT imm);
        rvIsaPkg::instT w;
        case (kind)
            kAdd:  w = {7'b0000000, rs2, rs1, 3'b000, rd, rvIsaPkg::opR};
            kSub:  w = {7'b0100000, rs2, rs1, 3'b000, rd, rvIsaPkg::opR};
            kAnd:  w = {7'b0000000, rs2, rs1, 3'b111, rd, rvIsaPkg::opR};
            kOr:   w = {7'b0000000, rs2, rs1, 3'b110, rd, rvIsaPkg::opR};
            kSlt:  w = {7'b0000000, rs2, rs1, 3'b010, rd, rvIsaPkg::opR};
            kAddi: w = {imm[11:0], rs1, 3'b000, rd, rvIsaPkg::opImm};
            kAndi: w = {imm[11:0], rs1, 3'b111, rd, rvIsaPkg::opImm};
            kOri:  w = {imm[11:0], rs1, 3'b110, rd, rvIsaPkg::opImm};
            kLw:   w = {imm[11:0], rs1, 3'b010, rd, rvIsaPkg::opLoad};
            kSw:   w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvIsaPkg::opStore};
            kBeq:  w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                        rvIsaPkg::opBranch};
            default: w = {imm[31:7], imm[0] ? 7'b0001011 : 7'b0110111}; // custom-0 or lui
        endcase
        return w;
    endfunction

    task automatic genProgram();
        kindT             kind;
        rvIsaPkg::regIdxT rd;
        rvIsaPkg::regIdxT rs1;
        rvIsaPkg::regIdxT rs2;
        cpuCorePkg::wordT imm;
        for (int i = 0; i < progWords; i++) begin
            rngState = xorshift(rngState);
            kind = (i == 0) ? kAddi : kindT'(rngState % 12); // No store in first cycle
            rd   = {2'b00, rngState[10:8]};
            rs1  = {2'b00, rngState[13:11]};
            rs2  = {2'b00, rngState[16:14]};
            rngState = xorshift(rngState);
            imm = {{20{rngState[11]}}, rngState[11:0]};
            if (kind == kLw || kind == kSw) begin
                rs1 = '0;
                imm = {24'd0, rngState[5:0], 2'b00}; // Inside the data window
            end else if (kind == kBeq) begin
                imm = (32'(rngState[1:0]) + 32'd1) * 32'd4; // 1 to 4 words forward
            end
            if (i >= haltWord) begin
                kind = kBeq;
                rs1  = '0;
                rs2  = '0;
                imm  = '0;
            end
            progKind[i] = kind;
            progRd[i]   = rd;
            progRs1[i]  = rs1;
            progRs2[i]  = rs2;
            progImm[i]  = imm;
            imem[i]     = encode(kind, rd, rs1, rs2, imm);
        end
    endtask

    // Retires the instruction at mPc
    task automatic modelStep();
        int               w;
        cpuCorePkg::wordT a;
        cpuCorePkg::wordT b;
        cpuCorePkg::wordT addr;
        cpuCorePkg::wordT res;
        logic             wr;
        w    = int'(mPc[9:2]);
        a    = mRegs[progRs1[w][2:0]];
        b    = mRegs[progRs2[w][2:0]];
        addr = a + progImm[w];
        res  = '0;
        wr   = 1'b1;
        mPc  = mPc + 32'd4;
        case (progKind[w])
            kAdd:  res = a + b;
            kSub:  res = a - b;
            kAnd:  res = a & b;
            kOr:   res = a | b;
            kSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            kAddi: res = a + progImm[w];
            kAndi: res = a & progImm[w];
            kOri:  res = a | progImm[w];
            kLw:   res = mMem[addr[7:2]];
            kSw: begin
                mMem[addr[7:2]] = b;
                wr = 1'b0;
            end
            kBeq: begin
                if (a == b) begin
                    mPc = mPc - 32'd4 + progImm[w];
                end
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && progRd[w] != '0) begin
            mRegs[progRd[w][2:0]] = res;
        end
    endtask

    initial begin
        int             cycles;
        int             w;
        logic           halted;
        rvIsaPkg::instT firstInst;
        rstN     = 1'b0;
        rngState = 32'hc96f;
        mPc      = 32'h0;
        genProgram();
        for (int i = 0; i < dataWords; i++) begin
            dmem[i] = 32'h3c5a0000 ^ (i * 32'h9e3779b9);
            mMem[i] = dmem[i];
        end
        for (int i = 0; i < 8; i++) begin
            mRegs[i] = '0;
        end
        // Store at the reset vector while held in reset
        firstInst = imem[0];
        imem[0]   = encode(kSw, 5'd0, 5'd0, 5'd1, 32'd0);
        for (int i = 0; i < 16; i++) begin
            @(negedge CLK);
            checkEq("reset instAddr", 32'h0, instAddr);
            checkEq("reset memWe", 32'h0, memWe);
        end
        @(posedge CLK);
        rstN    <= 1'b1;
        imem[0] <= firstInst;
        cycles = 0;
        halted = 1'b0;
        while (!halted) begin
            @(negedge CLK);
            w = int'(mPc[9:2]);
            checkEq($sformatf("fetch cycle %0d", cycles), mPc, instAddr);
            checkEq($sformatf("memWe cycle %0d", cycles), progKind[w] == kSw, memWe);
            if (progKind[w] == kSw) begin
                checkEq($sformatf("store addr cycle %0d", cycles),
                        mRegs[progRs1[w][2:0]] + progImm[w], memAddr);
                checkEq($sformatf("store data cycle %0d", cycles),
                        mRegs[progRs2[w][2:0]], memWdata);
            end
            if (mPc >= haltWord * 4) begin
                halted = 1'b1;
            end else begin
                modelStep();
            end
            cycles++;
            if (!halted && cycles >= maxCycles) begin
                $display("Core did not reach the halt address within %0d cycles", maxCycles);
                $display("Test failures found");
                $fatal(1, "Timeout");
            end
        end
        for (int i = 0; i < dataWords; i++) begin
            checkEq($sformatf("dmem word %0d", i), mMem[i], dmem[i]);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
